// File: hw/fetch_pkg.sv
package fetch_pkg;

    // Datapath widths
    localparam int PC_WIDTH    = 32;
    localparam int INSTR_WIDTH = 32;
    localparam int IMM_WIDTH   = 16;

    // BTB geometry
    localparam int BTB_DEPTH       = 8;
    localparam int BTB_INDEX_WIDTH = 3;

    // Program ROM, word addressed from PC bits 7 to 2
    localparam int    ROM_DEPTH      = 64;
    localparam int    ROM_ADDR_WIDTH = 6;
    localparam int    ROM_ADDR_LSB   = 2;
    localparam string ROM_FILE       = "verif/program.hex";

    localparam logic [PC_WIDTH-1:0] RESET_PC = 32'h0000_0000;
    localparam logic [PC_WIDTH-1:0] PC_STEP  = 32'd4;

    // Instruction fields
    localparam int OPCODE_MSB = 31;
    localparam int OPCODE_LSB = 28;
    localparam int IMM_MSB    = 15;
    localparam int IMM_LSB    = 0;

    typedef enum logic [3:0] {
        OP_NOP  = 4'h0,
        OP_SETC = 4'h1, // Counter <= imm
        OP_LOOP = 4'h2, // Counter--, taken to imm while non-zero
        OP_JMP  = 4'h3, // Always taken to imm
        OP_HALT = 4'h4
    } opcode_t;

    typedef enum logic {
        FETCH_RUN  = 1'b0,
        FETCH_HALT = 1'b1
    } fetch_state_t;

endpackage

// File: hw/branch_target_buffer.sv
`timescale 1ns/1ps

module branch_target_buffer
    import fetch_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  logic [PC_WIDTH-1:0] lookup_pc,
    input  logic                btb_update,
    input  logic [PC_WIDTH-1:0] btb_update_pc,
    input  logic [PC_WIDTH-1:0] btb_update_target,
    output logic [PC_WIDTH-1:0] lookup_target,
    output logic                lookup_hit,
    output logic                btb_first
);

    // Entry storage, fully associative
    logic                       entry_valid  [BTB_DEPTH];
    logic [PC_WIDTH-1:0]        entry_pc     [BTB_DEPTH];
    logic [PC_WIDTH-1:0]        entry_target [BTB_DEPTH];
    logic [BTB_INDEX_WIDTH-1:0] next_insert; // Round-robin victim

    logic                       rd_match;
    logic [BTB_INDEX_WIDTH-1:0] rd_index;
    logic                       wr_match;
    logic [BTB_INDEX_WIDTH-1:0] wr_index;

    // Returns {found, index}; scanning downward leaves the lowest match
    function automatic logic [BTB_INDEX_WIDTH:0] match_entry(
        input logic [PC_WIDTH-1:0] key
    );
        logic [BTB_INDEX_WIDTH:0] result;
        result = '0;
        for (int i = BTB_DEPTH - 1; i >= 0; i--) begin
            if (entry_valid[i] && (entry_pc[i] == key)) begin
                result = {1'b1, BTB_INDEX_WIDTH'(i)};
            end
        end
        return result;
    endfunction

    always_comb begin
        {rd_match, rd_index} = match_entry(lookup_pc);
        {wr_match, wr_index} = match_entry(btb_update_pc);
    end

    // Lookup port
    always_comb begin
        lookup_hit = rd_match;
        if (rd_match) begin
            lookup_target = entry_target[rd_index];
        end else begin
            lookup_target = lookup_pc + PC_STEP; // Fall through on a miss
        end
    end

    // Valid bits, insert pointer and the new-entry strobe
    always_ff @(posedge clk) begin
        if (!reset) begin
            for (int i = 0; i < BTB_DEPTH; i++) begin
                entry_valid[i] <= 1'b0;
            end
            next_insert <= '0;
            btb_first   <= 1'b0;
        end else begin
            btb_first <= 1'b0;
            if (btb_update && !wr_match) begin
                entry_valid[next_insert] <= 1'b1;
                btb_first                <= 1'b1;
                if (next_insert == BTB_INDEX_WIDTH'(BTB_DEPTH - 1)) begin
                    next_insert <= '0;
                end else begin
                    next_insert <= next_insert + 1'b1;
                end
            end
        end
    end

    // Tag and target storage
    always_ff @(posedge clk) begin
        if (btb_update) begin
            if (wr_match) begin
                entry_target[wr_index] <= btb_update_target; // Retarget only
            end else begin
                entry_pc[next_insert]     <= btb_update_pc;
                entry_target[next_insert] <= btb_update_target;
            end
        end
    end

endmodule

// File: hw/instr_rom.sv
`timescale 1ns/1ps

module instr_rom
    import fetch_pkg::*;
(
    input  logic [ROM_ADDR_WIDTH-1:0] rom_addr,
    output logic [INSTR_WIDTH-1:0]    rom_data
);

    logic [INSTR_WIDTH-1:0] mem [ROM_DEPTH];

    // Words past the end of the image read as NOP
    initial begin
        for (int i = 0; i < ROM_DEPTH; i++) begin
            mem[i] = '0;
        end
        $readmemh(ROM_FILE, mem);
    end

    assign rom_data = mem[rom_addr]; // Asynchronous read

endmodule

// File: hw/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage
    import fetch_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic [PC_WIDTH-1:0]    lookup_target,
    input  logic [INSTR_WIDTH-1:0] rom_data,
    input  logic                   redirect,
    input  logic [PC_WIDTH-1:0]    redirect_pc,
    input  logic                   halt_req,
    output logic [PC_WIDTH-1:0]    fetch_pc,
    output logic                   ex_valid,
    output logic [PC_WIDTH-1:0]    ex_pc,
    output logic [INSTR_WIDTH-1:0] ex_instr,
    output logic [PC_WIDTH-1:0]    ex_pred_pc
);

    fetch_state_t        state;
    logic [PC_WIDTH-1:0] pc;

    assign fetch_pc = pc;

    // PC and run/halt control
    always_ff @(posedge clk) begin
        if (!reset) begin
            state    <= FETCH_RUN;
            pc       <= RESET_PC;
            ex_valid <= 1'b0;
        end else begin
            case (state)
                FETCH_RUN: begin
                    if (halt_req) begin
                        state    <= FETCH_HALT; // Freeze, drop the fetched word
                        ex_valid <= 1'b0;
                    end else if (redirect) begin
                        pc       <= redirect_pc;
                        ex_valid <= 1'b0; // One bubble
                    end else begin
                        pc       <= lookup_target; // Predicted next PC
                        ex_valid <= 1'b1;
                    end
                end
                default: begin
                    ex_valid <= 1'b0; // Stays halted until reset
                end
            endcase
        end
    end

    // Fetch-to-execute payload, qualified by ex_valid
    always_ff @(posedge clk) begin
        ex_pc      <= pc;
        ex_instr   <= rom_data;
        ex_pred_pc <= lookup_target;
    end

endmodule

// File: hw/execute_stage.sv
`timescale 1ns/1ps

module execute_stage
    import fetch_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   ex_valid,
    input  logic [PC_WIDTH-1:0]    ex_pc,
    input  logic [INSTR_WIDTH-1:0] ex_instr,
    input  logic [PC_WIDTH-1:0]    ex_pred_pc,
    input  logic                   btb_first,
    output logic                   redirect,
    output logic [PC_WIDTH-1:0]    redirect_pc,
    output logic                   halt_req,
    output logic                   btb_update,
    output logic [PC_WIDTH-1:0]    btb_update_pc,
    output logic [PC_WIDTH-1:0]    btb_update_target,
    output logic                   retire_valid,
    output logic [PC_WIDTH-1:0]    retire_pc,
    output logic                   retire_mispredict,
    output logic                   retire_btb_new,
    output logic                   halted
);

    opcode_t              opcode;
    logic [IMM_WIDTH-1:0] imm;
    logic [IMM_WIDTH-1:0] loop_count;
    logic [IMM_WIDTH-1:0] count_dec;
    logic                 taken;
    logic                 is_halt;
    logic [PC_WIDTH-1:0]  actual_pc;

    assign opcode    = opcode_t'(ex_instr[OPCODE_MSB:OPCODE_LSB]);
    assign imm       = ex_instr[IMM_MSB:IMM_LSB];
    assign count_dec = loop_count - 1'b1;

    // Branch resolution
    always_comb begin
        taken   = 1'b0;
        is_halt = 1'b0;
        case (opcode)
            OP_LOOP: taken   = (count_dec != '0);
            OP_JMP:  taken   = 1'b1;
            OP_HALT: is_halt = 1'b1;
            default: ;                              // NOP, SETC and unknown codes
        endcase
        actual_pc = taken ? PC_WIDTH'(imm) : ex_pc + PC_STEP;
    end

    // A HALT never redirects, whatever was predicted after it
    assign redirect    = ex_valid && !is_halt && (actual_pc != ex_pred_pc);
    assign redirect_pc = actual_pc;
    assign halt_req    = ex_valid && is_halt;

    // Only taken branches train the BTB
    assign btb_update        = ex_valid && taken;
    assign btb_update_pc     = ex_pc;
    assign btb_update_target = actual_pc;

    // Loop counter
    always_ff @(posedge clk) begin
        if (!reset) begin
            loop_count <= '0;
        end else if (ex_valid) begin
            if (opcode == OP_SETC) begin
                loop_count <= imm;
            end else if (opcode == OP_LOOP) begin
                loop_count <= count_dec;
            end
        end
    end

    // Retire report, one cycle behind execute
    always_ff @(posedge clk) begin
        if (!reset) begin
            retire_valid      <= 1'b0;
            retire_pc         <= '0;
            retire_mispredict <= 1'b0;
            halted            <= 1'b0;
        end else begin
            retire_valid      <= ex_valid;
            retire_pc         <= ex_pc;
            retire_mispredict <= redirect;
            if (halt_req) begin
                halted <= 1'b1; // Sticky until reset
            end
        end
    end

    // BTB registers its flag at the same edge as retire_valid
    assign retire_btb_new = btb_first;

endmodule

// File: hw/branch_frontend_top.sv
`timescale 1ns/1ps

module branch_frontend_top
    import fetch_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    output logic                retire_valid,
    output logic [PC_WIDTH-1:0] retire_pc,
    output logic                retire_mispredict,
    output logic                retire_btb_new,
    output logic                halted
);

    logic [PC_WIDTH-1:0]    fetch_pc;
    logic [PC_WIDTH-1:0]    lookup_target;
    logic [INSTR_WIDTH-1:0] rom_data;
    logic                   ex_valid;
    logic [PC_WIDTH-1:0]    ex_pc;
    logic [INSTR_WIDTH-1:0] ex_instr;
    logic [PC_WIDTH-1:0]    ex_pred_pc;
    logic                   redirect;
    logic [PC_WIDTH-1:0]    redirect_pc;
    logic                   halt_req;
    logic                   btb_update;
    logic [PC_WIDTH-1:0]    btb_update_pc;
    logic [PC_WIDTH-1:0]    btb_update_target;
    logic                   btb_first;

    fetch_stage fetch_i (
        .clk           (clk),
        .reset         (reset),
        .lookup_target (lookup_target),
        .rom_data      (rom_data),
        .redirect      (redirect),
        .redirect_pc   (redirect_pc),
        .halt_req      (halt_req),
        .fetch_pc      (fetch_pc),
        .ex_valid      (ex_valid),
        .ex_pc         (ex_pc),
        .ex_instr      (ex_instr),
        .ex_pred_pc    (ex_pred_pc)
    );

    instr_rom rom_i (
        .rom_addr (fetch_pc[ROM_ADDR_LSB+ROM_ADDR_WIDTH-1:ROM_ADDR_LSB]),
        .rom_data (rom_data)
    );

    // Hit flag is folded into the target, fetch does not need it
    branch_target_buffer btb_i (
        .clk               (clk),
        .reset             (reset),
        .lookup_pc         (fetch_pc),
        .btb_update        (btb_update),
        .btb_update_pc     (btb_update_pc),
        .btb_update_target (btb_update_target),
        .lookup_target     (lookup_target),
        .lookup_hit        (),
        .btb_first         (btb_first)
    );

    execute_stage execute_i (
        .clk               (clk),
        .reset             (reset),
        .ex_valid          (ex_valid),
        .ex_pc             (ex_pc),
        .ex_instr          (ex_instr),
        .ex_pred_pc        (ex_pred_pc),
        .btb_first         (btb_first),
        .redirect          (redirect),
        .redirect_pc       (redirect_pc),
        .halt_req          (halt_req),
        .btb_update        (btb_update),
        .btb_update_pc     (btb_update_pc),
        .btb_update_target (btb_update_target),
        .retire_valid      (retire_valid),
        .retire_pc         (retire_pc),
        .retire_mispredict (retire_mispredict),
        .retire_btb_new    (retire_btb_new),
        .halted            (halted)
    );

endmodule

// File: verif/frontend_checker.sv
`timescale 1ns/1ps

module frontend_checker
    import fetch_pkg::*;
(
    input logic                clk,
    input logic                reset,
    input logic                retire_valid,
    input logic [PC_WIDTH-1:0] retire_pc,
    input logic                retire_mispredict,
    input logic                retire_btb_new,
    input logic                halted
);

    // Synchronous reset clears every output at the next edge
    reset_clears_outputs: assert property (@(posedge clk)
        !reset |=> (!retire_valid && !retire_mispredict && !retire_btb_new && !halted
                    && (retire_pc == '0)))
        else $error("outputs not cleared by reset");

    // Retire flags only qualify a retire strobe
    flags_need_retire: assert property (@(posedge clk) disable iff (!reset)
        (retire_mispredict || retire_btb_new) |-> retire_valid)
        else $error("retire flag without retire_valid");

    halted_is_sticky: assert property (@(posedge clk) disable iff (!reset)
        halted |=> halted)
        else $error("halted fell without reset");

    // HALT retires with halted and nothing retires after it
    no_retire_after_halt: assert property (@(posedge clk) disable iff (!reset)
        halted |=> !retire_valid)
        else $error("retire after halt");

    retire_pc_aligned: assert property (@(posedge clk) disable iff (!reset)
        retire_valid |-> (retire_pc[1:0] == 2'b00))
        else $error("retire_pc not word aligned");

endmodule

bind branch_frontend_top frontend_checker checker_i (
    .clk               (clk),
    .reset             (reset),
    .retire_valid      (retire_valid),
    .retire_pc         (retire_pc),
    .retire_mispredict (retire_mispredict),
    .retire_btb_new    (retire_btb_new),
    .halted            (halted)
);

// File: verif/frontend_tb.sv
`timescale 1ns/1ps

module frontend_tb
    import fetch_pkg::*;
;

    localparam int CLK_PERIOD     = 40;
    localparam int DRIVE_DELAY    = 1;
    localparam int RETIRE_TIMEOUT = 50; // Cycles allowed between retires
    localparam int QUIET_WINDOW   = 30;
    localparam int MAX_RETIRES    = 200;

    logic                clk;
    logic                reset;
    logic                retire_valid;
    logic [PC_WIDTH-1:0] retire_pc;
    logic                retire_mispredict;
    logic                retire_btb_new;
    logic                halted;

    logic [INSTR_WIDTH-1:0] rom_image [ROM_DEPTH];

    // Reference model state
    logic [PC_WIDTH-1:0]        model_pc;
    logic [IMM_WIDTH-1:0]       model_count;
    logic                       model_halted;
    logic                       m_valid  [BTB_DEPTH];
    logic [PC_WIDTH-1:0]        m_pc     [BTB_DEPTH];
    logic [PC_WIDTH-1:0]        m_target [BTB_DEPTH];
    logic [BTB_INDEX_WIDTH-1:0] m_next;
    logic [IMM_WIDTH-1:0]       last_setc;

    int  test_errors;
    int  tests_passed;
    int  tests_failed;
    int  loop_retires;
    int  mispredicts;
    int  exp_mispredicts;
    int  first_loop_mispredicts;
    bit  timed_out;

    branch_frontend_top dut_i (
        .clk               (clk),
        .reset             (reset),
        .retire_valid      (retire_valid),
        .retire_pc         (retire_pc),
        .retire_mispredict (retire_mispredict),
        .retire_btb_new    (retire_btb_new),
        .halted            (halted)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic void value_error(string test, string field, logic [31:0] exp,
                                        logic [31:0] act);
        $display("FAIL %s %s expected %h actual %h", test, field, exp, act);
        test_errors++;
    endfunction

    function automatic void clear_model();
        for (int i = 0; i < BTB_DEPTH; i++) begin
            m_valid[i] = 1'b0;
        end
        model_pc     = RESET_PC;
        model_count  = '0;
        model_halted = 1'b0;
        m_next       = '0;
    endfunction

    task automatic apply_reset();
        @(posedge clk);
        #DRIVE_DELAY reset = 1'b0;
        repeat (3) @(posedge clk);
        #DRIVE_DELAY reset = 1'b1;
        clear_model();
    endtask

    // Waits for the next retire strobe, sampled at the falling edge
    task automatic wait_retire(string test, output bit seen);
        seen = 1'b0;
        for (int c = 0; c < RETIRE_TIMEOUT && !seen; c++) begin
            @(negedge clk);
            seen = retire_valid;
        end
        if (!seen) begin
            $display("ERROR %s: timed out waiting for an instruction to retire", test);
            test_errors++;
            timed_out = 1'b1;
        end
    endtask

    task automatic check_retire(string test);
        bit                  seen;
        logic [PC_WIDTH-1:0] pc;
        logic [PC_WIDTH-1:0] pred;
        logic [PC_WIDTH-1:0] actual;
        logic [INSTR_WIDTH-1:0] instr;
        logic [3:0]          op;
        logic [IMM_WIDTH-1:0] imm;
        bit                  hit;
        int                  idx;
        bit                  taken;
        bit                  is_halt;
        bit                  exp_mis;
        bit                  exp_new;
        wait_retire(test, seen);
        if (!seen) return;
        // Count what the DUT actually retired
        if (rom_image[retire_pc[ROM_ADDR_LSB +: ROM_ADDR_WIDTH]][31:28] == OP_LOOP) begin
            loop_retires++;
        end
        if (retire_mispredict) begin
            mispredicts++;
        end
        pc    = model_pc;
        instr = rom_image[pc[ROM_ADDR_LSB +: ROM_ADDR_WIDTH]];
        op    = instr[31:28];
        imm   = instr[15:0];
        hit   = 1'b0;
        idx   = 0;
        pred  = pc + 4; // Miss predicts fall through
        for (int i = 0; i < BTB_DEPTH; i++) begin
            if (!hit && m_valid[i] && m_pc[i] == pc) begin
                hit  = 1'b1;
                idx  = i;
                pred = m_target[i];
            end
        end
        taken   = 1'b0;
        is_halt = 1'b0;
        if (op == OP_SETC) begin
            model_count = imm;
            last_setc   = imm;
        end else if (op == OP_LOOP) begin
            model_count = model_count - 1'b1;
            taken       = (model_count != 0);
        end else if (op == OP_JMP) begin
            taken = 1'b1;
        end else if (op == OP_HALT) begin
            is_halt = 1'b1;
        end
        actual  = taken ? {16'h0, imm} : pc + 4;
        exp_mis = !is_halt && (actual != pred);
        exp_new = taken && !hit;
        if (taken && hit) begin
            m_target[idx] = actual;
        end else if (taken) begin
            m_valid[m_next]  = 1'b1;
            m_pc[m_next]     = pc;
            m_target[m_next] = actual;
            m_next           = m_next + 1'b1; // Wraps at 8
        end
        if (is_halt) model_halted = 1'b1;
        if (exp_mis) exp_mispredicts++;
        model_pc = actual;
        assert (retire_pc == pc) else value_error(test, "retire_pc", pc, retire_pc);
        assert (retire_mispredict == exp_mis)
            else value_error(test, "retire_mispredict", exp_mis, retire_mispredict);
        assert (retire_btb_new == exp_new)
            else value_error(test, "retire_btb_new", exp_new, retire_btb_new);
        assert (halted == model_halted) else value_error(test, "halted", model_halted, halted);
    endtask

    // Retires until the model's next PC reaches stop_pc
    task automatic run_until(string test, logic [PC_WIDTH-1:0] stop_pc);
        int n;
        n = 0;
        while (model_pc != stop_pc && !timed_out && n < MAX_RETIRES) begin
            check_retire(test);
            n++;
        end
        if (n >= MAX_RETIRES) begin
            $display("ERROR %s: program flow never reached %h", test, stop_pc);
            test_errors++;
        end
    endtask

    task automatic finish_test(string test);
        if (test_errors == 0) begin
            $display("test %s: passed", test);
            tests_passed++;
        end else begin
            $display("test %s: failed with %0d errors", test, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    initial begin
        reset           = 1'b0;
        test_errors     = 0;
        tests_passed    = 0;
        tests_failed    = 0;
        loop_retires    = 0;
        mispredicts     = 0;
        exp_mispredicts = 0;
        timed_out       = 1'b0;
        for (int i = 0; i < ROM_DEPTH; i++) begin
            rom_image[i] = '0;
        end
        $readmemh(ROM_FILE, rom_image);
        apply_reset();

        mispredicts = 0;
        run_until("sequential", 32'h0C);
        assert (mispredicts == 0) else value_error("sequential", "mispredicts", 0, mispredicts);
        finish_test("sequential");

        loop_retires    = 0;
        mispredicts     = 0;
        exp_mispredicts = 0;
        run_until("counted_loop", 32'h14);
        assert (loop_retires == last_setc)
            else value_error("counted_loop", "loop_retires", last_setc, loop_retires);
        first_loop_mispredicts = exp_mispredicts;
        finish_test("counted_loop");

        run_until("jump_chain_replacement", 32'h60);
        finish_test("jump_chain_replacement");
        run_until("jump_revisit", 32'h74);
        finish_test("jump_revisit");

        check_retire("halt");
        assert (halted) else value_error("halt", "halted", 1, halted);
        for (int c = 0; c < QUIET_WINDOW; c++) begin
            @(negedge clk);
            if (retire_valid) begin
                $display("ERROR halt: an instruction retired after HALT");
                test_errors++;
            end
        end
        finish_test("halt");

        // Restart and reset again partway through the loop
        apply_reset();
        run_until("reset_mid_loop", 32'h0C);
        check_retire("reset_mid_loop");
        check_retire("reset_mid_loop");
        apply_reset();
        run_until("reset_mid_loop", 32'h0C);
        mispredicts = 0;
        run_until("reset_mid_loop", 32'h14);
        assert (mispredicts == first_loop_mispredicts)
            else value_error("reset_mid_loop", "mispredicts", first_loop_mispredicts,
                             mispredicts);
        finish_test("reset_mid_loop");

        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && !timed_out) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: verif/program.hex
// One instruction word per line, word address 0 upward
// Bits 31..28 opcode (0 NOP, 1 SETC, 2 LOOP, 3 JMP, 4 HALT), bits 15..0 immediate
00000000
00000000
10000003
00000000
2000000C
30000020
00000000
00000000
30000028
00000000
30000030
00000000
30000038
00000000
30000040
00000000
30000048
00000000
30000050
00000000
30000058
00000000
30000060
00000000
10000002
30000070
00000000
00000000
20000064
40000000
00000000
00000000

// File: sim.f
hw/fetch_pkg.sv
hw/branch_target_buffer.sv
hw/instr_rom.sv
hw/fetch_stage.sv
hw/execute_stage.sv
hw/branch_frontend_top.sv
verif/frontend_checker.sv
verif/frontend_tb.sv
